//--- flight_pkg.sv
// Shared widths, rule limits and word types for the flight path
// Stick, axis rate and IMU word types

package flight_pkg;

    // Word widths
    localparam int STICK_W = 8;
    localparam int RATE_W = 16;
    localparam int IMU_W = 16;

    // Widened widths for error and mixing arithmetic
    localparam int ERR_W = 18;
    localparam int MIX_W = 18;

    // Tick counter widths for pulse capture and ESC frames
    localparam int PULSE_CNT_W = 12;
    localparam int FRAME_CNT_W = 12;

    // Unsigned stick value, 0 to 250
    typedef logic [STICK_W-1:0] stick_t;

    // Signed axis rate command
    typedef logic signed [RATE_W-1:0] rate_t;

    // Signed IMU angle or rate
    typedef logic signed [IMU_W-1:0] imu_word_t;

    // Stick range, also the motor rate range
    localparam int STICK_MAX = 250;
    localparam int STICK_CENTER = 125;

    // Pulse timing in microsecond ticks
    localparam int PULSE_MIN_TICKS = 1000;
    localparam int TICKS_PER_STEP = 4;
    localparam int FRAME_TICKS = 2500;

    // Controller limits
    localparam int RATE_LIMIT = 100;
    localparam int KP_SHIFT = 1;
    localparam int ARM_LEVEL = 10;

endpackage

//--- flight_ifs.sv
// Interfaces between the flight pipeline stages
// Decoded sticks, axis commands and motor rates

`timescale 1ns/10ps

// Receiver sticks plus the all-channels-seen flag
interface stick_if import flight_pkg::*; ();
    stick_t throttle;
    stick_t roll;
    stick_t pitch;
    stick_t yaw;
    // High once every channel finished a pulse
    logic   seen;

    modport drv (output throttle, roll, pitch, yaw, seen);
    modport rd (input throttle, roll, pitch, yaw, seen);
endinterface

// Throttle and per-axis rate commands
interface axis_cmd_if import flight_pkg::*; ();
    stick_t throttle;
    rate_t  roll_cmd;
    rate_t  pitch_cmd;
    rate_t  yaw_cmd;

    modport drv (output throttle, roll_cmd, pitch_cmd, yaw_cmd);
    modport rd (input throttle, roll_cmd, pitch_cmd, yaw_cmd);
endinterface

// Motor rates, 0 to STICK_MAX each
interface motor_cmd_if import flight_pkg::*; ();
    stick_t motor_1;
    stick_t motor_2;
    stick_t motor_3;
    stick_t motor_4;

    modport drv (output motor_1, motor_2, motor_3, motor_4);
    modport rd (input motor_1, motor_2, motor_3, motor_4);
endinterface

//--- rc_receiver.sv
// RC receiver pulse capture
// Measures four pulse widths in ticks and converts them to stick values

`timescale 1ns/10ps

module rc_receiver import flight_pkg::*; (
    input  logic sys_clk,
    input  logic resetn,
    input  logic tick,
    input  logic throttle_pwm,
    input  logic roll_pwm,
    input  logic pitch_pwm,
    input  logic yaw_pwm,
    stick_if.drv sticks
);

    // Widest pulse that still maps inside the stick range
    localparam int PULSE_MAX_TICKS = PULSE_MIN_TICKS + TICKS_PER_STEP * STICK_MAX;

    // Channel order is throttle, roll, pitch, yaw
    logic [3:0] pwm_in;
    logic [3:0] seen_ch;
    stick_t     stick_val [4];

    assign pwm_in = {yaw_pwm, pitch_pwm, roll_pwm, throttle_pwm};

    for (genvar i = 0; i < 4; i++) begin : g_chan
        logic                   pwm_q;
        logic                   fall;
        logic [PULSE_CNT_W-1:0] width_cnt;
        logic                   seen_q;
        stick_t                 stick_q;

        // Falling edge of the pulse
        assign fall = pwm_q & ~pwm_in[i];

        always_ff @(posedge sys_clk or negedge resetn) begin
            if (!resetn) begin
                pwm_q     <= 1'b0;
                width_cnt <= '0;
            end else begin
                pwm_q <= pwm_in[i];
                // Count ticks while high, hold at full scale
                if (!pwm_in[i]) begin
                    width_cnt <= '0;
                end else if (tick && width_cnt != '1) begin
                    width_cnt <= width_cnt + 1'b1;
                end
            end
        end

        // Convert the finished width into a clamped stick value
        always_ff @(posedge sys_clk or negedge resetn) begin
            if (!resetn) begin
                stick_q <= '0;
                seen_q  <= 1'b0;
            end else if (fall) begin
                seen_q <= 1'b1;
                if (width_cnt < PULSE_MIN_TICKS) begin
                    stick_q <= '0;
                end else if (width_cnt >= PULSE_MAX_TICKS) begin
                    stick_q <= stick_t'(STICK_MAX);
                end else begin
                    stick_q <= stick_t'((width_cnt - PULSE_MIN_TICKS) / TICKS_PER_STEP);
                end
            end
        end

        assign seen_ch[i]   = seen_q;
        assign stick_val[i] = stick_q;
    end

    assign sticks.throttle = stick_val[0];
    assign sticks.roll     = stick_val[1];
    assign sticks.pitch    = stick_val[2];
    assign sticks.yaw      = stick_val[3];
    // All four channels have delivered a pulse
    assign sticks.seen     = &seen_ch;

endmodule

//--- attitude_controller.sv
// Attitude controller
// Latched IMU sample, per-axis error and clamped proportional rate commands

`timescale 1ns/10ps

module attitude_controller import flight_pkg::*; (
    input  logic      sys_clk,
    input  logic      resetn,
    input  logic      att_en,
    input  imu_word_t imu_roll_angle,
    input  imu_word_t imu_pitch_angle,
    input  imu_word_t imu_yaw_rate,
    stick_if.rd       sticks,
    axis_cmd_if.drv   cmds
);

    // IMU sample as seen on the strobe cycle
    imu_word_t roll_angle_q;
    imu_word_t pitch_angle_q;
    imu_word_t yaw_rate_q;

    stick_t throttle_q;
    rate_t  roll_cmd_q;
    rate_t  pitch_cmd_q;
    rate_t  yaw_cmd_q;

    // Centred stick target minus measurement, shifted and clamped
    function automatic rate_t p_term(input stick_t target, input imu_word_t meas);
        logic signed [ERR_W-1:0] target_x;
        logic signed [ERR_W-1:0] err;
        logic signed [ERR_W-1:0] scaled;
        target_x = $signed({{(ERR_W-STICK_W){1'b0}}, target});
        err      = target_x - ERR_W'(STICK_CENTER) - ERR_W'(meas);
        // Arithmetic shift rounds toward minus infinity
        scaled   = err >>> KP_SHIFT;
        if (scaled > ERR_W'(RATE_LIMIT)) begin
            return rate_t'(RATE_LIMIT);
        end else if (scaled < -ERR_W'(RATE_LIMIT)) begin
            return -rate_t'(RATE_LIMIT);
        end
        return rate_t'(scaled);
    endfunction

    // Sample register, one cycle ahead of att_en
    always_ff @(posedge sys_clk) begin
        roll_angle_q  <= imu_roll_angle;
        pitch_angle_q <= imu_pitch_angle;
        yaw_rate_q    <= imu_yaw_rate;
    end

    // Commands hold between enables
    always_ff @(posedge sys_clk or negedge resetn) begin
        if (!resetn) begin
            throttle_q  <= '0;
            roll_cmd_q  <= '0;
            pitch_cmd_q <= '0;
            yaw_cmd_q   <= '0;
        end else if (att_en) begin
            throttle_q  <= sticks.throttle;
            roll_cmd_q  <= p_term(sticks.roll, roll_angle_q);
            pitch_cmd_q <= p_term(sticks.pitch, pitch_angle_q);
            // Yaw works on rate rather than angle
            yaw_cmd_q   <= p_term(sticks.yaw, yaw_rate_q);
        end
    end

    assign cmds.throttle  = throttle_q;
    assign cmds.roll_cmd  = roll_cmd_q;
    assign cmds.pitch_cmd = pitch_cmd_q;
    assign cmds.yaw_cmd   = yaw_cmd_q;

endmodule

//--- motor_mixer.sv
// Quad-X motor mixer
// Throttle and axis commands into four clamped motor rates

`timescale 1ns/10ps

module motor_mixer import flight_pkg::*; (
    input  logic     sys_clk,
    input  logic     resetn,
    input  logic     mix_en,
    input  logic     armed,
    axis_cmd_if.rd   cmds,
    motor_cmd_if.drv motors
);

    logic signed [MIX_W-1:0] thr_x;
    logic signed [MIX_W-1:0] roll_x;
    logic signed [MIX_W-1:0] pitch_x;
    logic signed [MIX_W-1:0] yaw_x;
    logic signed [MIX_W-1:0] sum [4];
    stick_t                  motor_q [4];

    // Saturate a mixed sum into the motor range
    function automatic stick_t mix_clamp(input logic signed [MIX_W-1:0] mix_sum);
        if (mix_sum < 0) begin
            return '0;
        end else if (mix_sum > MIX_W'(STICK_MAX)) begin
            return stick_t'(STICK_MAX);
        end
        return stick_t'(mix_sum);
    endfunction

    always_comb begin
        thr_x   = $signed({{(MIX_W-STICK_W){1'b0}}, cmds.throttle});
        roll_x  = MIX_W'(cmds.roll_cmd);
        pitch_x = MIX_W'(cmds.pitch_cmd);
        yaw_x   = MIX_W'(cmds.yaw_cmd);
        // Front pair gains pitch, diagonals share yaw sign
        sum[0]  = thr_x + pitch_x + roll_x - yaw_x;
        sum[1]  = thr_x + pitch_x - roll_x + yaw_x;
        sum[2]  = thr_x - pitch_x - roll_x - yaw_x;
        sum[3]  = thr_x - pitch_x + roll_x + yaw_x;
    end

    always_ff @(posedge sys_clk or negedge resetn) begin
        if (!resetn) begin
            for (int i = 0; i < 4; i++) begin
                motor_q[i] <= '0;
            end
        end else if (mix_en) begin
            // Motors idle until armed
            for (int i = 0; i < 4; i++) begin
                motor_q[i] <= armed ? mix_clamp(sum[i]) : '0;
            end
        end
    end

    assign motors.motor_1 = motor_q[0];
    assign motors.motor_2 = motor_q[1];
    assign motors.motor_3 = motor_q[2];
    assign motors.motor_4 = motor_q[3];

endmodule

//--- esc_pwm_generator.sv
// ESC pulse generator
// Frame counter and four pulse outputs loaded at frame start

`timescale 1ns/10ps

module esc_pwm_generator import flight_pkg::*; (
    input  logic   sys_clk,
    input  logic   resetn,
    input  logic   tick,
    motor_cmd_if.rd motors,
    output logic   motor_1_pwm,
    output logic   motor_2_pwm,
    output logic   motor_3_pwm,
    output logic   motor_4_pwm
);

    logic [FRAME_CNT_W-1:0] frame_cnt;
    logic                   frame_start;
    logic [3:0]             pwm_out;
    stick_t                 rate [4];

    assign rate[0] = motors.motor_1;
    assign rate[1] = motors.motor_2;
    assign rate[2] = motors.motor_3;
    assign rate[3] = motors.motor_4;

    // Last tick of the frame
    assign frame_start = tick && (frame_cnt == FRAME_CNT_W'(FRAME_TICKS - 1));

    always_ff @(posedge sys_clk or negedge resetn) begin
        if (!resetn) begin
            frame_cnt <= '0;
        end else if (tick) begin
            frame_cnt <= frame_start ? '0 : frame_cnt + 1'b1;
        end
    end

    for (genvar i = 0; i < 4; i++) begin : g_motor
        logic [FRAME_CNT_W-1:0] pulse_len;
        logic                   pwm_q;

        always_ff @(posedge sys_clk or negedge resetn) begin
            if (!resetn) begin
                pulse_len <= '0;
                pwm_q     <= 1'b0;
            end else begin
                // Rate is only taken at the frame boundary
                if (frame_start) begin
                    pulse_len <= FRAME_CNT_W'(PULSE_MIN_TICKS + TICKS_PER_STEP * rate[i]);
                end
                pwm_q <= frame_cnt < pulse_len;
            end
        end

        assign pwm_out[i] = pwm_q;
    end

    assign motor_1_pwm = pwm_out[0];
    assign motor_2_pwm = pwm_out[1];
    assign motor_3_pwm = pwm_out[2];
    assign motor_4_pwm = pwm_out[3];

endmodule

//--- flight_sequencer.sv
// Flight sequencer
// Microsecond tick, stage enables and the arming flag

`timescale 1ns/10ps

module flight_sequencer import flight_pkg::*; #(
    parameter int TICK_CYCLES = 38
) (
    input  logic sys_clk,
    input  logic resetn,
    input  logic imu_valid,
    stick_if.rd  sticks,
    output logic tick,
    output logic att_en,
    output logic mix_en,
    output logic armed
);

    // Divider width, at least one bit
    localparam int TICK_W = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;

    logic [TICK_W-1:0] div_cnt;
    logic              div_wrap;

    assign div_wrap = (div_cnt == TICK_W'(TICK_CYCLES - 1));

    // One-cycle tick every TICK_CYCLES clocks
    always_ff @(posedge sys_clk or negedge resetn) begin
        if (!resetn) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else begin
            div_cnt <= div_wrap ? '0 : div_cnt + 1'b1;
            tick    <= div_wrap;
        end
    end

    // Strobe moves attitude stage, then mixer stage
    always_ff @(posedge sys_clk or negedge resetn) begin
        if (!resetn) begin
            att_en <= 1'b0;
            mix_en <= 1'b0;
        end else begin
            att_en <= imu_valid;
            mix_en <= att_en;
        end
    end

    // Arm on low throttle, stay armed until reset
    always_ff @(posedge sys_clk or negedge resetn) begin
        if (!resetn) begin
            armed <= 1'b0;
        end else if (sticks.seen && sticks.throttle < ARM_LEVEL) begin
            armed <= 1'b1;
        end
    end

endmodule

//--- drone_core.sv
// Flight control top level
// Receiver, attitude, mixer and ESC stages under one sequencer

`timescale 1ns/10ps

module drone_core import flight_pkg::*; #(
    parameter int TICK_CYCLES = 38
) (
    input  logic      sys_clk,
    input  logic      resetn,
    // RC receiver pulses
    input  logic      throttle_pwm,
    input  logic      roll_pwm,
    input  logic      pitch_pwm,
    input  logic      yaw_pwm,
    // IMU sample and strobe
    input  logic      imu_valid,
    input  imu_word_t imu_roll_angle,
    input  imu_word_t imu_pitch_angle,
    input  imu_word_t imu_yaw_rate,
    // ESC pulses
    output logic      motor_1_pwm,
    output logic      motor_2_pwm,
    output logic      motor_3_pwm,
    output logic      motor_4_pwm,
    output logic      armed
);

    logic tick;
    logic att_en;
    logic mix_en;

    stick_if     sticks ();
    axis_cmd_if  cmds ();
    motor_cmd_if motors ();

    flight_sequencer #(.TICK_CYCLES(TICK_CYCLES)) i_sequencer (
        .sys_clk(sys_clk), .resetn(resetn), .imu_valid(imu_valid), .sticks(sticks),
        .tick(tick), .att_en(att_en), .mix_en(mix_en), .armed(armed)
    );

    rc_receiver i_receiver (
        .sys_clk(sys_clk), .resetn(resetn), .tick(tick),
        .throttle_pwm(throttle_pwm), .roll_pwm(roll_pwm),
        .pitch_pwm(pitch_pwm), .yaw_pwm(yaw_pwm), .sticks(sticks)
    );

    attitude_controller i_attitude (
        .sys_clk(sys_clk), .resetn(resetn), .att_en(att_en),
        .imu_roll_angle(imu_roll_angle), .imu_pitch_angle(imu_pitch_angle),
        .imu_yaw_rate(imu_yaw_rate), .sticks(sticks), .cmds(cmds)
    );

    motor_mixer i_mixer (
        .sys_clk(sys_clk), .resetn(resetn), .mix_en(mix_en), .armed(armed),
        .cmds(cmds), .motors(motors)
    );

    esc_pwm_generator i_esc (
        .sys_clk(sys_clk), .resetn(resetn), .tick(tick), .motors(motors),
        .motor_1_pwm(motor_1_pwm), .motor_2_pwm(motor_2_pwm),
        .motor_3_pwm(motor_3_pwm), .motor_4_pwm(motor_4_pwm)
    );

endmodule

//--- tb_drone_core.sv
// Testbench for the flight control top level
// Reads drone_tests.txt, drives RC pulses and IMU samples, measures ESC pulses

`timescale 1ns/10ps

module tb_drone_core import flight_pkg::*; ();

    localparam int TICK_CYCLES = 2;
    localparam int MAX_TESTS = 32;
    // RC frame just longer than the widest test pulse
    localparam int RC_FRAME_TICKS = 2300;
    // Window that covers the longest ESC pulse
    localparam int MEASURE_TICKS = PULSE_MIN_TICKS + TICKS_PER_STEP * STICK_MAX + 50;
    localparam int FRAMES_PER_TEST = 5;

    logic      sys_clk;
    logic      resetn;
    logic      throttle_pwm;
    logic      roll_pwm;
    logic      pitch_pwm;
    logic      yaw_pwm;
    logic      imu_valid;
    imu_word_t imu_roll_angle;
    imu_word_t imu_pitch_angle;
    imu_word_t imu_yaw_rate;
    logic      motor_1_pwm;
    logic      motor_2_pwm;
    logic      motor_3_pwm;
    logic      motor_4_pwm;
    logic      armed;

    // Test table from the data file
    string test_name [MAX_TESTS];
    int    rc_width [MAX_TESTS][4];
    int    imu_val [MAX_TESTS][3];
    int    exp_width [MAX_TESTS][4];
    int    exp_armed [MAX_TESTS];
    int    num_tests;
    bit    tests_loaded;
    int    err_count;
    int    pass_count;
    int    fail_count;
    // Motor widths in ticks from the last measurement
    int    measured [4];

    drone_core #(.TICK_CYCLES(TICK_CYCLES)) i_dut (
        .sys_clk(sys_clk), .resetn(resetn),
        .throttle_pwm(throttle_pwm), .roll_pwm(roll_pwm),
        .pitch_pwm(pitch_pwm), .yaw_pwm(yaw_pwm), .imu_valid(imu_valid),
        .imu_roll_angle(imu_roll_angle), .imu_pitch_angle(imu_pitch_angle),
        .imu_yaw_rate(imu_yaw_rate),
        .motor_1_pwm(motor_1_pwm), .motor_2_pwm(motor_2_pwm),
        .motor_3_pwm(motor_3_pwm), .motor_4_pwm(motor_4_pwm), .armed(armed)
    );

    initial begin
        sys_clk = 1'b0;
        forever #4 sys_clk = ~sys_clk;
    end

    // Watchdog, budget of a few ESC frames per test
    initial begin : watchdog
        longint limit_ns;
        wait (tests_loaded);
        limit_ns = longint'(num_tests) * FRAMES_PER_TEST * FRAME_TICKS * TICK_CYCLES * 8;
        #(limit_ns);
        $display("Timeout: tests did not finish within %0d ns", limit_ns);
        $display("Done: errors found");
        $finish;
    end

    task automatic check_value(input string name, input string what,
                               input int expected, input int actual);
        if (expected != actual) begin
            err_count++;
            $display("FAIL %s %s expected %0d actual %0d", name, what, expected, actual);
        end
    endtask

    task automatic read_tests();
        int    fd;
        int    n;
        string line;
        string nm;
        int    v [12];
        fd = $fopen("drone_tests.txt", "r");
        if (fd == 0) begin
            return;
        end
        while (!$feof(fd) && num_tests < MAX_TESTS) begin
            line = "";
            void'($fgets(line, fd));
            // Skip comments and blank lines
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d", nm, v[0], v[1],
                        v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11]);
            if (n == 13) begin
                test_name[num_tests] = nm;
                for (int i = 0; i < 4; i++) begin
                    rc_width[num_tests][i]  = v[i];
                    exp_width[num_tests][i] = v[7 + i];
                end
                for (int i = 0; i < 3; i++) begin
                    imu_val[num_tests][i] = v[4 + i];
                end
                exp_armed[num_tests] = v[11];
                num_tests++;
            end
        end
        $fclose(fd);
    endtask

    // All four channels rise together, each falls after its width
    task automatic drive_rc_frame(input int t);
        for (int c = 0; c < RC_FRAME_TICKS * TICK_CYCLES; c++) begin
            @(posedge sys_clk);
            throttle_pwm <= (c < rc_width[t][0] * TICK_CYCLES);
            roll_pwm     <= (c < rc_width[t][1] * TICK_CYCLES);
            pitch_pwm    <= (c < rc_width[t][2] * TICK_CYCLES);
            yaw_pwm      <= (c < rc_width[t][3] * TICK_CYCLES);
        end
    endtask

    // One-cycle strobe, sample held afterwards
    task automatic pulse_imu(input int t);
        @(posedge sys_clk);
        imu_valid       <= 1'b1;
        imu_roll_angle  <= imu_word_t'(imu_val[t][0]);
        imu_pitch_angle <= imu_word_t'(imu_val[t][1]);
        imu_yaw_rate    <= imu_word_t'(imu_val[t][2]);
        @(posedge sys_clk);
        imu_valid <= 1'b0;
    endtask

    // Returns on the first sample of a new ESC pulse
    task automatic wait_frame_start();
        logic prev;
        @(negedge sys_clk);
        prev = motor_1_pwm;
        @(negedge sys_clk);
        while (prev || !motor_1_pwm) begin
            prev = motor_1_pwm;
            @(negedge sys_clk);
        end
    endtask

    task automatic measure_pulses();
        int high_cycles [4];
        for (int i = 0; i < 4; i++) begin
            high_cycles[i] = 0;
        end
        repeat (MEASURE_TICKS * TICK_CYCLES) begin
            high_cycles[0] += int'(motor_1_pwm);
            high_cycles[1] += int'(motor_2_pwm);
            high_cycles[2] += int'(motor_3_pwm);
            high_cycles[3] += int'(motor_4_pwm);
            @(negedge sys_clk);
        end
        for (int i = 0; i < 4; i++) begin
            measured[i] = high_cycles[i] / TICK_CYCLES;
        end
    endtask

    task automatic run_test(input int t);
        int errs_before;
        errs_before = err_count;
        drive_rc_frame(t);
        drive_rc_frame(t);
        pulse_imu(t);
        // Pulse after the second frame start carries the new rates
        wait_frame_start();
        wait_frame_start();
        measure_pulses();
        for (int i = 0; i < 4; i++) begin
            check_value(test_name[t], $sformatf("motor_%0d width", i + 1),
                        exp_width[t][i], measured[i]);
        end
        check_value(test_name[t], "armed", exp_armed[t], int'(armed));
        if (err_count == errs_before) begin
            pass_count++;
            $display("PASS %s", test_name[t]);
        end else begin
            fail_count++;
            $display("test %s had %0d mismatches", test_name[t], err_count - errs_before);
        end
    endtask

    initial begin : main
        resetn          = 1'b0;
        throttle_pwm    = 1'b0;
        roll_pwm        = 1'b0;
        pitch_pwm       = 1'b0;
        yaw_pwm         = 1'b0;
        imu_valid       = 1'b0;
        imu_roll_angle  = '0;
        imu_pitch_angle = '0;
        imu_yaw_rate    = '0;
        num_tests       = 0;
        err_count       = 0;
        pass_count      = 0;
        fail_count      = 0;
        read_tests();
        if (num_tests == 0) begin
            $display("No tests could be read from drone_tests.txt");
            $display("Done: errors found");
        end else begin
            tests_loaded = 1'b1;
            repeat (5) @(posedge sys_clk);
            resetn <= 1'b1;
            for (int t = 0; t < num_tests; t++) begin
                run_test(t);
            end
            $display("Tests passed %0d, failed %0d", pass_count, fail_count);
            if (fail_count == 0) begin
                $display("Done: no errors");
            end else begin
                $display("Done: errors found");
            end
        end
        $finish;
    end

endmodule

//--- drone_tests.txt
# name thr_w roll_w pitch_w yaw_w imu_roll imu_pitch imu_yaw m1_w m2_w m3_w m4_w armed
# RC and motor widths in ticks, IMU values signed, tests run in order
disarmed_high_throttle 1500 1500 1500 1500 0 0 0 1000 1000 1000 1000 0
arm_low_throttle 1036 1500 1500 1500 0 0 0 1036 1036 1036 1036 1
hover_mid 1500 1500 1500 1500 0 0 0 1500 1500 1500 1500 1
hover_odd_width 1603 1500 1500 1500 0 0 0 1600 1600 1600 1600 1
roll_correction 1500 1500 1500 1500 10 0 0 1480 1520 1520 1480 1
attitude_negative_round 1500 1540 1500 1460 3 5 -4 1512 1464 1512 1512 1
rate_clamp_roll_pitch 1500 1500 1500 1500 400 -300 0 1500 2000 1500 1000 1
rate_clamp_yaw 1800 1500 1500 1500 0 0 -500 1400 2000 1400 2000 1
rc_clamp_high 2200 1500 1500 1500 0 0 0 2000 2000 2000 2000 1
rc_clamp_low 900 1500 1500 1500 0 0 0 1000 1000 1000 1000 1
rc_clamp_roll_low 1500 900 1500 1500 0 0 0 1248 1752 1752 1248 1

//--- drone_core.f
flight_pkg.sv
flight_ifs.sv
rc_receiver.sv
attitude_controller.sv
motor_mixer.sv
esc_pwm_generator.sv
flight_sequencer.sv
drone_core.sv
tb_drone_core.sv

//--- Makefile
# Verilator build, run, lint and clean for the flight control project

.PHONY: all lint clean

all:
	verilator --binary --timing -Wno-fatal --top-module tb_drone_core -f drone_core.f -o sim_drone
	@out=$$(./obj_dir/sim_drone); echo "$$out"; echo "$$out" | grep -q "^Done: no errors$$"

lint:
	verilator --lint-only --timing -Wall --top-module drone_core -f drone_core.f

clean:
	rm -rf obj_dir
